// File: Makefile
# Verilator build, run, lint and clean for the DAC transport layer

TOP = tb_dac_tpl

.PHONY: all lint clean

all:
	verilator --binary --assert -Wno-fatal -f all.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: all.f
dac_tpl_pkg.sv
dac_ctrl_pkg.sv
dac_pn_gen.sv
dac_tone_gen.sv
dac_iq_correct.sv
dac_channel.sv
dac_tpl.sv
dac_tpl_checker.sv
tb_dac_tpl.sv

// File: dac_channel.sv
// Per-channel source selector, registers the chosen lane group and the enable flag
`timescale 1ns/1ps

module dac_channel (
  input  logic                      clk,
  input  logic                      reset,
  input  dac_tpl_pkg::dac_lanes_t   dma_data,
  input  dac_tpl_pkg::dac_lanes_t   iq_data,
  input  dac_tpl_pkg::dac_lanes_t   pn7_data,
  input  dac_tpl_pkg::dac_lanes_t   pn15_data,
  input  logic                      data_sync,
  input  logic                      dds_valid,
  input  logic                      dds_format,
  input  dac_ctrl_pkg::dac_src_t    data_sel,
  input  logic                      mask_enable,
  input  dac_ctrl_pkg::tone_word_t  init_0,
  input  dac_ctrl_pkg::tone_word_t  incr_0,
  input  dac_ctrl_pkg::tone_word_t  scale_0,
  input  dac_ctrl_pkg::tone_word_t  init_1,
  input  dac_ctrl_pkg::tone_word_t  incr_1,
  input  dac_ctrl_pkg::tone_word_t  scale_1,
  input  dac_tpl_pkg::dac_sample_t  pat_data_0,
  input  dac_tpl_pkg::dac_sample_t  pat_data_1,
  input  logic                      iqcor_enable,
  input  dac_ctrl_pkg::iq_coeff_t   coeff_1,
  input  dac_ctrl_pkg::iq_coeff_t   coeff_2,
  output dac_tpl_pkg::dac_lanes_t   dac_data,
  output logic                      dac_enable
);

  import dac_tpl_pkg::*;
  import dac_ctrl_pkg::*;

  dac_lanes_t tone_data;
  dac_lanes_t iqcor_data;
  dac_lanes_t pat_data;

  // ********************************************************
  // Sources
  // ********************************************************

  // Alternating pattern, even lanes word 0, odd lanes word 1
  assign pat_data = {(lane_count/2){pat_data_1, pat_data_0}};

  // Tone path, 3 cycles from sync
  dac_tone_gen tone_gen (
    .clk        (clk),
    .reset      (reset),
    .data_sync  (data_sync),
    .dds_valid  (dds_valid),
    .dds_format (dds_format),
    .init_0     (init_0),
    .incr_0     (incr_0),
    .scale_0    (scale_0),
    .init_1     (init_1),
    .incr_1     (incr_1),
    .scale_1    (scale_1),
    .tone_data  (tone_data)
  );

  // DMA path, second operand from the other channel
  dac_iq_correct iq_correct (
    .clk          (clk),
    .reset        (reset),
    .iqcor_enable (iqcor_enable),
    .coeff_1      (coeff_1),
    .coeff_2      (coeff_2),
    .data_in      (dma_data),
    .iq_data      (iq_data),
    .data_out     (iqcor_data)
  );

  // ********************************************************
  // Output select
  // ********************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      dac_data   <= '0;
      dac_enable <= 1'b0;
    end else begin
      // DMA is only requested when selected and not masked
      dac_enable <= !mask_enable && (data_sel == src_dma);
      if (mask_enable) begin
        dac_data <= iqcor_data;
      end else begin
        case (data_sel)
          src_pn15:     dac_data <= pn15_data;
          src_pn7:      dac_data <= pn7_data;
          src_pn15_inv: dac_data <= ~pn15_data;
          src_pn7_inv:  dac_data <= ~pn7_data;
          src_zero:     dac_data <= '0;
          src_dma:      dac_data <= iqcor_data;
          src_pattern:  dac_data <= pat_data;
          default:      dac_data <= tone_data; // tone and reserved codes
        endcase
      end
    end
  end

  // Reserved codes are legal but point at a bad register write
  assert property (@(posedge clk) disable iff (reset)
    !mask_enable |-> (data_sel <= src_pn15))
    else $error("dac_channel: reserved select code %0d", data_sel);

endmodule

// File: dac_ctrl_pkg.sv
// Control package: source select codes, correction and tone word types

package dac_ctrl_pkg;

  // ********************************************************
  // Source select
  // ********************************************************

  // Per-channel source codes
  // Codes 8 to 15 are reserved and fall back to the tone generator
  typedef enum logic [3:0] {
    src_tone     = 4'd0,
    src_pattern  = 4'd1,
    src_dma      = 4'd2,
    src_zero     = 4'd3,
    src_pn7_inv  = 4'd4,
    src_pn15_inv = 4'd5,
    src_pn7      = 4'd6,
    src_pn15     = 4'd7
  } dac_src_t;

  // ********************************************************
  // Correction and tone words
  // ********************************************************

  // Signed Q2.14 IQ correction coefficient
  typedef logic [15:0] iq_coeff_t;

  // Phase, increment or scale word of one tone
  typedef logic [15:0] tone_word_t;

  // Fraction bits of the coefficient format
  localparam int iq_frac_bits = 14;

  // PN start state, wide enough for PN15
  // PN7 uses only the low 7 bits
  localparam logic [14:0] pn_seed = '1;

endpackage

// File: dac_iq_correct.sv
// Two-stage IQ correction with saturation and a matched-latency bypass
`timescale 1ns/1ps

module dac_iq_correct (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    iqcor_enable,
  input  dac_ctrl_pkg::iq_coeff_t coeff_1,
  input  dac_ctrl_pkg::iq_coeff_t coeff_2,
  input  dac_tpl_pkg::dac_lanes_t data_in,
  input  dac_tpl_pkg::dac_lanes_t iq_data,
  output dac_tpl_pkg::dac_lanes_t data_out
);

  import dac_tpl_pkg::*;
  import dac_ctrl_pkg::*;

  // Stage 1 products per lane
  logic signed [31:0] prod_1 [lane_count];
  logic signed [31:0] prod_2 [lane_count];

  dac_lanes_t sat_data;

  // Clip to the signed 16-bit range
  function automatic dac_sample_t saturate(input logic signed [32:0] v);
    if (v > 33'sd32767) begin
      return 16'h7fff;
    end else if (v < -33'sd32768) begin
      return 16'h8000;
    end
    return v[15:0];
  endfunction

  // ********************************************************
  // Stage 1, multiply
  // ********************************************************

  // Bypass rides the same register as a pre-shifted sample
  // so both paths see two cycles
  always_ff @(posedge clk) begin
    for (int k = 0; k < lane_count; k++) begin
      if (iqcor_enable) begin
        prod_1[k] <= $signed(data_in[k*sample_width +: sample_width]) * $signed(coeff_1);
        prod_2[k] <= $signed(iq_data[k*sample_width +: sample_width]) * $signed(coeff_2);
      end else begin
        prod_1[k] <= 32'($signed(data_in[k*sample_width +: sample_width])) <<< iq_frac_bits;
        prod_2[k] <= '0;
      end
    end
  end

  // ********************************************************
  // Stage 2, accumulate, truncate and saturate
  // ********************************************************

  always_comb begin
    logic signed [32:0] acc;
    sat_data = '0;
    for (int k = 0; k < lane_count; k++) begin
      acc = 33'(prod_1[k]) + 33'(prod_2[k]);
      // Truncating shift, no rounding
      sat_data[k*sample_width +: sample_width] = saturate(acc >>> iq_frac_bits);
    end
  end

  always_ff @(posedge clk) begin
    data_out <= sat_data;
  end

  // Known inputs two cycles back must give a known output
  assert property (@(posedge clk) disable iff (reset)
    !$isunknown({$past(data_in, 2), $past(iq_data, 2), $past(coeff_1, 2),
                 $past(coeff_2, 2), $past(iqcor_enable, 2)}) |-> !$isunknown(data_out))
    else $error("dac_iq_correct: unknown output from known inputs");

endmodule

// File: dac_pn_gen.sv
// Shared PN7 and PN15 generator, 64 sequence bits per clock for both channels
`timescale 1ns/1ps

module dac_pn_gen (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    data_sync,
  output dac_tpl_pkg::dac_lanes_t pn7_data,
  output dac_tpl_pkg::dac_lanes_t pn15_data
);

  import dac_tpl_pkg::*;
  import dac_ctrl_pkg::*;

  // LFSR states, PN7 lives in the low 7 bits
  logic [14:0] pn7_state;
  logic [14:0] pn15_state;
  logic [14:0] pn7_base;
  logic [14:0] pn15_base;
  logic [14:0] pn7_next;
  logic [14:0] pn15_next;
  dac_lanes_t  pn7_group;
  dac_lanes_t  pn15_group;

  // ********************************************************
  // LFSR unrolled over one lane group
  // ********************************************************

  // Feedback is the XOR of the two top taps of a width-bit register
  // The new bit is the sequence bit and shifts in at the bottom
  // Bit j of the group lands in lane j/16, first bit at the sample MSB
  function automatic dac_lanes_t pn_run(input logic [14:0] state_in, input int width,
                                        output logic [14:0] state_out);
    logic [14:0] s;
    logic        fb;
    dac_lanes_t  group;
    s = state_in;
    group = '0;
    for (int j = 0; j < $bits(dac_lanes_t); j++) begin
      fb = s[width-1] ^ s[width-2];
      s = {s[13:0], fb};
      group[(j / sample_width) * sample_width + sample_width - 1 - (j % sample_width)] = fb;
    end
    // Clear the bits above the register width
    state_out = s & ((15'd1 << width) - 15'd1);
    return group;
  endfunction

  // Sync restarts both sequences from the seed in the same cycle
  always_comb begin
    pn7_base  = data_sync ? pn_seed : pn7_state;
    pn15_base = data_sync ? pn_seed : pn15_state;
    pn7_group  = pn_run(pn7_base, 7, pn7_next);
    pn15_group = pn_run(pn15_base, 15, pn15_next);
  end

  // LFSR state registers
  always_ff @(posedge clk) begin
    if (reset) begin
      pn7_state  <= pn_seed;
      pn15_state <= pn_seed;
    end else begin
      pn7_state  <= pn7_next;
      pn15_state <= pn15_next;
    end
  end

  // Output groups, first seeded group one cycle after sync
  always_ff @(posedge clk) begin
    pn7_data  <= pn7_group;
    pn15_data <= pn15_group;
  end

  // A locked-up LFSR would stall both channels on a constant
  assert property (@(posedge clk) disable iff (reset)
    (pn7_state[6:0] != 7'd0) && (pn15_state != 15'd0))
    else $error("dac_pn_gen: LFSR reached the all-zero state");

endmodule

// File: dac_tone_gen.sv
// Two-tone triangle generator with phase accumulation, scaling and output format
`timescale 1ns/1ps

module dac_tone_gen (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     data_sync,
  input  logic                     dds_valid,
  input  logic                     dds_format,
  input  dac_ctrl_pkg::tone_word_t init_0,
  input  dac_ctrl_pkg::tone_word_t incr_0,
  input  dac_ctrl_pkg::tone_word_t scale_0,
  input  dac_ctrl_pkg::tone_word_t init_1,
  input  dac_ctrl_pkg::tone_word_t incr_1,
  input  dac_ctrl_pkg::tone_word_t scale_1,
  output dac_tpl_pkg::dac_lanes_t  tone_data
);

  import dac_tpl_pkg::*;
  import dac_ctrl_pkg::*;

  // Base phase of lane 0, one per tone
  tone_word_t phase_0;
  tone_word_t phase_1;

  // Scaled tone per lane
  logic signed [sample_width-1:0] tone_a [lane_count];
  logic signed [sample_width-1:0] tone_b [lane_count];

  dac_lanes_t tone_next;

  // ********************************************************
  // Triangle shape and scaling
  // ********************************************************

  // Fold the phase, then center it around zero
  function automatic logic signed [14:0] triangle(input tone_word_t p);
    logic [14:0] fold;
    fold = p[15] ? ~p[14:0] : p[14:0];
    return $signed(fold - 15'd16384);
  endfunction

  // Signed scale, keeps bits 30 to 15 of the product
  function automatic logic signed [15:0] tone_scale(input logic signed [14:0] tri_v,
                                                    input tone_word_t scale);
    logic signed [30:0] prod;
    prod = tri_v * $signed(scale);
    return prod[30:15];
  endfunction

  // Stage 1, phase accumulators
  // Sync wins over valid, valid low holds the phase
  always_ff @(posedge clk) begin
    if (reset) begin
      phase_0 <= '0;
      phase_1 <= '0;
    end else if (data_sync) begin
      phase_0 <= init_0;
      phase_1 <= init_1;
    end else if (dds_valid) begin
      phase_0 <= phase_0 + tone_word_t'(lane_count) * incr_0;
      phase_1 <= phase_1 + tone_word_t'(lane_count) * incr_1;
    end
  end

  // Stage 2, lane k runs k increments ahead of the base phase
  always_ff @(posedge clk) begin
    for (int k = 0; k < lane_count; k++) begin
      tone_a[k] <= tone_scale(triangle(phase_0 + tone_word_t'(k) * incr_0), scale_0);
      tone_b[k] <= tone_scale(triangle(phase_1 + tone_word_t'(k) * incr_1), scale_1);
    end
  end

  // Sum of both tones, wraps modulo 2^16
  always_comb begin
    logic [sample_width-1:0] lane_sum;
    tone_next = '0;
    for (int k = 0; k < lane_count; k++) begin
      lane_sum = tone_a[k] + tone_b[k];
      // MSB flip gives offset binary
      tone_next[k*sample_width +: sample_width] =
        {lane_sum[sample_width-1] ^ dds_format, lane_sum[sample_width-2:0]};
    end
  end

  // Stage 3, output register
  always_ff @(posedge clk) begin
    tone_data <= tone_next;
  end

endmodule

// File: dac_tpl.sv
// Transport layer top: shared PN generator feeding the I and Q channels
`timescale 1ns/1ps

module dac_tpl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     data_sync,
  input  logic                     dds_valid,
  input  dac_tpl_pkg::dac_lanes_t  dma_data_0,
  input  dac_tpl_pkg::dac_lanes_t  dma_data_1,
  input  dac_ctrl_pkg::dac_src_t   data_sel_0,
  input  dac_ctrl_pkg::dac_src_t   data_sel_1,
  input  logic                     mask_enable_0,
  input  logic                     mask_enable_1,
  input  logic                     dds_format_0,
  input  logic                     dds_format_1,
  input  dac_ctrl_pkg::tone_word_t init_0_0,
  input  dac_ctrl_pkg::tone_word_t incr_0_0,
  input  dac_ctrl_pkg::tone_word_t scale_0_0,
  input  dac_ctrl_pkg::tone_word_t init_1_0,
  input  dac_ctrl_pkg::tone_word_t incr_1_0,
  input  dac_ctrl_pkg::tone_word_t scale_1_0,
  input  dac_ctrl_pkg::tone_word_t init_0_1,
  input  dac_ctrl_pkg::tone_word_t incr_0_1,
  input  dac_ctrl_pkg::tone_word_t scale_0_1,
  input  dac_ctrl_pkg::tone_word_t init_1_1,
  input  dac_ctrl_pkg::tone_word_t incr_1_1,
  input  dac_ctrl_pkg::tone_word_t scale_1_1,
  input  dac_tpl_pkg::dac_sample_t pat_data_0_0,
  input  dac_tpl_pkg::dac_sample_t pat_data_1_0,
  input  dac_tpl_pkg::dac_sample_t pat_data_0_1,
  input  dac_tpl_pkg::dac_sample_t pat_data_1_1,
  input  logic                     iqcor_enable_0,
  input  logic                     iqcor_enable_1,
  input  dac_ctrl_pkg::iq_coeff_t  coeff_1_0,
  input  dac_ctrl_pkg::iq_coeff_t  coeff_2_0,
  input  dac_ctrl_pkg::iq_coeff_t  coeff_1_1,
  input  dac_ctrl_pkg::iq_coeff_t  coeff_2_1,
  output dac_tpl_pkg::dac_lanes_t  dac_data_0,
  output dac_tpl_pkg::dac_lanes_t  dac_data_1,
  output logic                     dac_enable_0,
  output logic                     dac_enable_1
);

  import dac_tpl_pkg::*;

  dac_lanes_t pn7_data;
  dac_lanes_t pn15_data;

  // One PN state for both channels
  dac_pn_gen pn_gen (
    .clk       (clk),
    .reset     (reset),
    .data_sync (data_sync),
    .pn7_data  (pn7_data),
    .pn15_data (pn15_data)
  );

  // ********************************************************
  // I channel, Q DMA data as correction operand
  // ********************************************************

  dac_channel channel_i (
    .clk          (clk),
    .reset        (reset),
    .dma_data     (dma_data_0),
    .iq_data      (dma_data_1),
    .pn7_data     (pn7_data),
    .pn15_data    (pn15_data),
    .data_sync    (data_sync),
    .dds_valid    (dds_valid),
    .dds_format   (dds_format_0),
    .data_sel     (data_sel_0),
    .mask_enable  (mask_enable_0),
    .init_0       (init_0_0),
    .incr_0       (incr_0_0),
    .scale_0      (scale_0_0),
    .init_1       (init_1_0),
    .incr_1       (incr_1_0),
    .scale_1      (scale_1_0),
    .pat_data_0   (pat_data_0_0),
    .pat_data_1   (pat_data_1_0),
    .iqcor_enable (iqcor_enable_0),
    .coeff_1      (coeff_1_0),
    .coeff_2      (coeff_2_0),
    .dac_data     (dac_data_0),
    .dac_enable   (dac_enable_0)
  );

  // Q channel, I DMA data crossed in
  dac_channel channel_q (
    .clk          (clk),
    .reset        (reset),
    .dma_data     (dma_data_1),
    .iq_data      (dma_data_0),
    .pn7_data     (pn7_data),
    .pn15_data    (pn15_data),
    .data_sync    (data_sync),
    .dds_valid    (dds_valid),
    .dds_format   (dds_format_1),
    .data_sel     (data_sel_1),
    .mask_enable  (mask_enable_1),
    .init_0       (init_0_1),
    .incr_0       (incr_0_1),
    .scale_0      (scale_0_1),
    .init_1       (init_1_1),
    .incr_1       (incr_1_1),
    .scale_1      (scale_1_1),
    .pat_data_0   (pat_data_0_1),
    .pat_data_1   (pat_data_1_1),
    .iqcor_enable (iqcor_enable_1),
    .coeff_1      (coeff_1_1),
    .coeff_2      (coeff_2_1),
    .dac_data     (dac_data_1),
    .dac_enable   (dac_enable_1)
  );

endmodule

// File: dac_tpl_checker.sv
// Checker for the DAC transport layer, models every source and compares both channels
`timescale 1ns/1ps

module dac_tpl_checker (
  input logic                     clk,
  input logic                     reset,
  input logic                     data_sync,
  input logic                     dds_valid,
  input dac_tpl_pkg::dac_lanes_t  dma_data_0,
  input dac_tpl_pkg::dac_lanes_t  dma_data_1,
  input dac_ctrl_pkg::dac_src_t   data_sel_0,
  input dac_ctrl_pkg::dac_src_t   data_sel_1,
  input logic                     mask_enable_0,
  input logic                     mask_enable_1,
  input logic                     dds_format_0,
  input logic                     dds_format_1,
  input dac_ctrl_pkg::tone_word_t init_0_0, incr_0_0, scale_0_0,
  input dac_ctrl_pkg::tone_word_t init_1_0, incr_1_0, scale_1_0,
  input dac_ctrl_pkg::tone_word_t init_0_1, incr_0_1, scale_0_1,
  input dac_ctrl_pkg::tone_word_t init_1_1, incr_1_1, scale_1_1,
  input dac_tpl_pkg::dac_sample_t pat_data_0_0, pat_data_1_0,
  input dac_tpl_pkg::dac_sample_t pat_data_0_1, pat_data_1_1,
  input logic                     iqcor_enable_0,
  input logic                     iqcor_enable_1,
  input dac_ctrl_pkg::iq_coeff_t  coeff_1_0, coeff_2_0,
  input dac_ctrl_pkg::iq_coeff_t  coeff_1_1, coeff_2_1,
  input dac_tpl_pkg::dac_lanes_t  dac_data_0,
  input dac_tpl_pkg::dac_lanes_t  dac_data_1,
  input logic                     dac_enable_0,
  input logic                     dac_enable_1
);

  import dac_tpl_pkg::*;
  import dac_ctrl_pkg::*;

  // Result counters
  int    error_count = 0;
  int    test_errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  string test_name = "none";
  event  test_begin;

  // Model state, index 0 is the I channel, 1 the Q channel
  logic [14:0] pn7_state;
  logic [14:0] pn15_state;
  logic [14:0] pn_next;
  dac_lanes_t  pn7_q;
  dac_lanes_t  pn15_q;
  tone_word_t  phase_a [2];
  tone_word_t  phase_b [2];
  dac_lanes_t  tone_sum [2];
  dac_lanes_t  tone_q [2];
  dac_lanes_t  iq_s1 [2];
  dac_lanes_t  iq_s2 [2];
  dac_lanes_t  exp_data [2];
  logic        exp_enable [2];
  logic        armed = 1'b0;

  // ********************************************************
  // Reference functions
  // ********************************************************

  // One LFSR shift, the feedback bit enters at bit 0 and is the sequence bit
  function automatic logic [14:0] pn_step(input logic [14:0] s, input int width);
    logic fb;
    fb = s[width-1] ^ s[width-2];
    return ((s << 1) | {14'd0, fb}) & ((15'd1 << width) - 15'd1);
  endfunction

  // Next 64 sequence bits, 16 per lane, first bit at the sample MSB
  function automatic dac_lanes_t pn_group(input logic [14:0] s_in, input int width,
                                          output logic [14:0] s_out);
    dac_lanes_t g;
    logic [14:0] s;
    s = s_in;
    for (int j = 0; j < lane_count * sample_width; j++) begin
      s = pn_step(s, width);
      g[(j / 16) * 16 + 15 - (j % 16)] = s[0];
    end
    s_out = s;
    return g;
  endfunction

  // Fold to 15 bits, then center on zero
  function automatic int triangle(input tone_word_t p);
    int fold;
    fold = int'(p[14:0]);
    if (p[15]) begin
      fold = 32767 - fold;
    end
    return fold - 16384;
  endfunction

  // One scaled tone value
  function automatic dac_sample_t tone_sample(input tone_word_t p, input tone_word_t scale);
    int prod;
    prod = triangle(p) * int'($signed(scale));
    return dac_sample_t'(prod >>> 15);
  endfunction

  // Two-tone sum per lane, before the format bit
  function automatic dac_lanes_t tone_group(input tone_word_t ph_a, inc_a, sc_a,
                                            input tone_word_t ph_b, inc_b, sc_b);
    dac_lanes_t g;
    for (int k = 0; k < lane_count; k++) begin
      g[k*sample_width +: sample_width] = tone_sample(ph_a + tone_word_t'(k) * inc_a, sc_a)
        + tone_sample(ph_b + tone_word_t'(k) * inc_b, sc_b);
    end
    return g;
  endfunction

  // a*c1 + b*c2, truncating shift, clipped to 16 bits
  function automatic dac_sample_t iq_correct(input dac_sample_t a, b, input iq_coeff_t c1, c2,
                                             input logic en);
    longint acc;
    if (!en) begin
      return a;
    end
    acc = longint'($signed(a)) * longint'($signed(c1)) + longint'($signed(b)) * longint'($signed(c2));
    acc = acc >>> iq_frac_bits;
    if (acc > 32767) begin
      return 16'h7fff;
    end else if (acc < -32768) begin
      return 16'h8000;
    end
    return dac_sample_t'(acc);
  endfunction

  function automatic dac_lanes_t iq_group(input dac_lanes_t own, other, input logic en,
                                          input iq_coeff_t c1, c2);
    dac_lanes_t g;
    for (int k = 0; k < lane_count; k++) begin
      g[k*16 +: 16] = iq_correct(own[k*16 +: 16], other[k*16 +: 16], c1, c2, en);
    end
    return g;
  endfunction

  // Even lanes word 0, odd lanes word 1
  function automatic dac_lanes_t pat_group(input dac_sample_t p0, p1);
    dac_lanes_t g;
    for (int k = 0; k < lane_count; k++) begin
      g[k*16 +: 16] = k[0] ? p1 : p0;
    end
    return g;
  endfunction

  // Source mux, mask forces the DMA path
  function automatic dac_lanes_t pick(input dac_src_t sel, input logic mask,
                                      input dac_lanes_t iq, pat, tone);
    if (mask) begin
      return iq;
    end
    case (sel)
      src_pattern:  return pat;
      src_dma:      return iq;
      src_zero:     return '0;
      src_pn7_inv:  return ~pn7_q;
      src_pn15_inv: return ~pn15_q;
      src_pn7:      return pn7_q;
      src_pn15:     return pn15_q;
      default:      return tone;
    endcase
  endfunction

  // ********************************************************
  // Models and comparison
  // ********************************************************

  task automatic compare(input string name, input logic [63:0] actual, expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      error_count++;
      test_errors++;
    end
  endtask

  // Tone pipeline of one channel, phase, then sum, then format
  task automatic tone_model(input int ch, input tone_word_t init_a, incr_a, scale_a,
                            input tone_word_t init_b, incr_b, scale_b, input logic fmt);
    tone_q[ch] = tone_sum[ch];
    for (int k = 0; k < lane_count; k++) begin
      tone_q[ch][k*16 + 15] = tone_sum[ch][k*16 + 15] ^ fmt;
    end
    tone_sum[ch] = tone_group(phase_a[ch], incr_a, scale_a, phase_b[ch], incr_b, scale_b);
    if (reset) begin
      phase_a[ch] = '0;
      phase_b[ch] = '0;
    end else if (data_sync) begin
      phase_a[ch] = init_a;
      phase_b[ch] = init_b;
    end else if (dds_valid) begin
      phase_a[ch] = phase_a[ch] + 16'd4 * incr_a;
      phase_b[ch] = phase_b[ch] + 16'd4 * incr_b;
    end
  endtask

  always @(posedge clk) begin
    // Outputs seen here come from the previous edge
    if (armed) begin
      compare("dac_data_0", dac_data_0, exp_data[0]);
      compare("dac_data_1", dac_data_1, exp_data[1]);
      compare("dac_enable_0", 64'(dac_enable_0), 64'(exp_enable[0]));
      compare("dac_enable_1", 64'(dac_enable_1), 64'(exp_enable[1]));
    end
    // Expected after this edge, from model state before it
    exp_data[0] = reset ? '0 : pick(data_sel_0, mask_enable_0, iq_s2[0],
                                    pat_group(pat_data_0_0, pat_data_1_0), tone_q[0]);
    exp_data[1] = reset ? '0 : pick(data_sel_1, mask_enable_1, iq_s2[1],
                                    pat_group(pat_data_0_1, pat_data_1_1), tone_q[1]);
    exp_enable[0] = !reset && !mask_enable_0 && (data_sel_0 == src_dma);
    exp_enable[1] = !reset && !mask_enable_1 && (data_sel_1 == src_dma);
    // IQ path, two stages, operands crossed between channels
    iq_s2 = iq_s1;
    iq_s1[0] = iq_group(dma_data_0, dma_data_1, iqcor_enable_0, coeff_1_0, coeff_2_0);
    iq_s1[1] = iq_group(dma_data_1, dma_data_0, iqcor_enable_1, coeff_1_1, coeff_2_1);
    // Shared PN, restarts from the seed on sync
    pn7_q = pn_group(data_sync ? pn_seed : pn7_state, 7, pn_next);
    pn7_state = reset ? pn_seed : pn_next;
    pn15_q = pn_group(data_sync ? pn_seed : pn15_state, 15, pn_next);
    pn15_state = reset ? pn_seed : pn_next;
    tone_model(0, init_0_0, incr_0_0, scale_0_0, init_1_0, incr_1_0, scale_1_0, dds_format_0);
    tone_model(1, init_0_1, incr_0_1, scale_0_1, init_1_1, incr_1_1, scale_1_1, dds_format_1);
    armed = 1'b1;
  end

  // ********************************************************
  // Test bookkeeping
  // ********************************************************

  always @(test_begin) begin
    test_errors = 0;
  end

  task automatic start_test(input string name);
    test_name = name;
    tests_run++;
    -> test_begin;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      $display("Test %s: passed", test_name);
    end else begin
      $display("Test %s: failed with %0d mismatches", test_name, test_errors);
      tests_failed++;
    end
  endtask

  task automatic report_totals();
    $display("Tests run: %0d, failed: %0d, mismatches: %0d", tests_run, tests_failed,
             error_count);
  endtask

endmodule

// File: dac_tpl_pkg.sv
// Transport layer datapath package: sample widths, lane count and lane group types

package dac_tpl_pkg;

  // ********************************************************
  // Datapath geometry
  // ********************************************************

  // Samples per clock on each channel
  localparam int lane_count = 4;

  // Converter resolution, equal to the DMA sample width
  localparam int sample_width = 16;

  // ********************************************************
  // Datapath vectors
  // ********************************************************

  // One converter sample
  // Signed or offset binary, depending on the source
  typedef logic [sample_width-1:0] dac_sample_t;

  // Group of four samples on one clock
  // Lane 0 sits in the LSBs and is the earliest in time
  typedef logic [lane_count*sample_width-1:0] dac_lanes_t;

endpackage

// File: tb_dac_tpl.sv
// Testbench for the DAC transport layer that runs each source test in turn
`timescale 1ns/1ps

module tb_dac_tpl;

  import dac_tpl_pkg::*;
  import dac_ctrl_pkg::*;

  // Six tests take about 950 cycles
  // The limit leaves a wide margin
  localparam int max_cycles = 2000;

  logic        clk, reset, data_sync, dds_valid;
  dac_lanes_t  dma_data_0, dma_data_1, dac_data_0, dac_data_1;
  dac_src_t    data_sel_0, data_sel_1;
  logic        mask_enable_0, mask_enable_1, dds_format_0, dds_format_1;
  logic        iqcor_enable_0, iqcor_enable_1, dac_enable_0, dac_enable_1;
  tone_word_t  init_0_0, incr_0_0, scale_0_0, init_1_0, incr_1_0, scale_1_0;
  tone_word_t  init_0_1, incr_0_1, scale_0_1, init_1_1, incr_1_1, scale_1_1;
  dac_sample_t pat_data_0_0, pat_data_1_0, pat_data_0_1, pat_data_1_1;
  iq_coeff_t   coeff_1_0, coeff_2_0, coeff_1_1, coeff_2_1;
  int          cycle_count = 0;

  dac_tpl dac_tpl_i (.*);

  // Watches every DUT port
  dac_tpl_checker checker_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Stops a stuck run
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: run still going after %0d cycles", max_cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // ********************************************************
  // Stimulus helpers
  // ********************************************************

  // Falling edges with fresh DMA data on both channels
  task automatic step(input int n);
    repeat (n) begin
      @(negedge clk);
      dma_data_0 = {$urandom, $urandom};
      dma_data_1 = {$urandom, $urandom};
    end
  endtask

  task automatic sync_pulse();
    data_sync = 1'b1;
    step(1);
    data_sync = 1'b0;
  endtask

  // ********************************************************
  // Tests
  // ********************************************************

  // Reset values, zero and pattern on both channels
  task automatic constants_and_pattern();
    checker_i.start_test("constants");
    step(1);
    reset = 1'b0;
    data_sel_0 = src_zero;
    data_sel_1 = src_zero;
    step(3);
    data_sel_0 = src_pattern;
    data_sel_1 = src_pattern;
    repeat (4) begin
      {pat_data_0_0, pat_data_1_0, pat_data_0_1, pat_data_1_1} = {$urandom, $urandom};
      step(3);
    end
    data_sel_0 = src_zero;
    data_sel_1 = src_zero;
    step(3);
    checker_i.end_test();
  endtask

  task automatic dma_passthrough();
    checker_i.start_test("dma passthrough");
    data_sel_0 = src_dma;
    data_sel_1 = src_dma;
    step(100);
    checker_i.end_test();
  endtask

  task automatic iq_correction();
    checker_i.start_test("iq correction");
    iqcor_enable_0 = 1'b1;
    iqcor_enable_1 = 1'b1;
    repeat (10) begin
      {coeff_1_0, coeff_2_0, coeff_1_1, coeff_2_1} = {$urandom, $urandom};
      step(20);
    end
    // Gains near plus and minus two clip at both limits
    {coeff_1_0, coeff_2_0, coeff_1_1, coeff_2_1} = {4{16'h7fff}};
    step(30);
    {coeff_1_0, coeff_2_0, coeff_1_1, coeff_2_1} = {4{16'h8000}};
    step(30);
    checker_i.end_test();
  endtask

  task automatic pn_sources();
    dac_src_t pn_sel [4] = '{src_pn15, src_pn7, src_pn15_inv, src_pn7_inv};
    checker_i.start_test("pn sources");
    for (int i = 0; i < 4; i++) begin
      data_sel_0 = pn_sel[i];
      data_sel_1 = pn_sel[(i + 1) % 4];
      sync_pulse();
      step(66);
    end
    checker_i.end_test();
  endtask

  task automatic tone_generator();
    checker_i.start_test("tone generator");
    {init_0_0, incr_0_0, scale_0_0, init_1_0, incr_1_0, scale_1_0} =
      {$urandom, $urandom, $urandom};
    {init_0_1, incr_0_1, scale_0_1, init_1_1, incr_1_1, scale_1_1} =
      {$urandom, $urandom, $urandom};
    data_sel_0 = src_tone;
    data_sel_1 = src_tone;
    dds_valid = 1'b1;
    sync_pulse();
    step(80);
    dds_format_0 = 1'b1;
    dds_format_1 = 1'b1;
    step(60);
    // Phase holds while valid is low
    dds_valid = 1'b0;
    step(20);
    dds_valid = 1'b1;
    step(20);
    checker_i.end_test();
  endtask

  task automatic mask_override();
    checker_i.start_test("mask");
    mask_enable_0 = 1'b1;
    mask_enable_1 = 1'b1;
    iqcor_enable_1 = 1'b0;
    for (int s = 0; s < 8; s++) begin
      data_sel_0 = dac_src_t'(s);
      data_sel_1 = dac_src_t'(7 - s);
      step(15);
    end
    checker_i.end_test();
  endtask

  initial begin
    void'($urandom(32'h4d01e916));
    reset = 1'b1;
    data_sync = 1'b0;
    dds_valid = 1'b0;
    dma_data_0 = '0;
    dma_data_1 = '0;
    // DMA select while in reset would raise dac_enable and pass DMA data without the reset
    data_sel_0 = src_dma;
    data_sel_1 = src_dma;
    {mask_enable_0, mask_enable_1, dds_format_0, dds_format_1} = '0;
    {iqcor_enable_0, iqcor_enable_1} = '0;
    {init_0_0, incr_0_0, scale_0_0, init_1_0, incr_1_0, scale_1_0} = '0;
    {init_0_1, incr_0_1, scale_0_1, init_1_1, incr_1_1, scale_1_1} = '0;
    {pat_data_0_0, pat_data_1_0, pat_data_0_1, pat_data_1_1} = '0;
    {coeff_1_0, coeff_2_0, coeff_1_1, coeff_2_1} = '0;
    step(1);
    constants_and_pattern();
    dma_passthrough();
    iq_correction();
    pn_sources();
    tone_generator();
    mask_override();
    checker_i.report_totals();
    if (checker_i.error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
